// File: all.f
mips_pkg.sv
decode_ctrl_if.sv
control.sv
alu.sv
regfile.sv
data_mem.sv
cpu.sv
tb_cpu.sv

// File: alu.sv
`default_nettype none

module alu import mips_pkg::*; (
	input  alu_class_t        alu_class,
	input  funct_t            funct,
	input  logic [xlen-1:0]   a,
	input  logic [xlen-1:0]   b,
	input  logic [4:0]        shamt,
	output logic [xlen-1:0]   result,
	output logic              zero
);

	alu_op_t op;

	// Resolve class and funct into one operation
	always_comb begin
		case (alu_class)
			cls_add: op = alu_add;
			cls_sub: op = alu_sub;
			cls_or:  op = alu_or;
			default: begin
				case (funct)
					fn_add:  op = alu_add;
					fn_sub:  op = alu_sub;
					fn_and:  op = alu_and;
					fn_or:   op = alu_or;
					fn_slt:  op = alu_slt;
					fn_sll:  op = alu_sll;
					default: op = alu_add;
				endcase
			end
		endcase
	end

	always_comb begin
		case (op)
			alu_add: result = a + b;
			alu_sub: result = a - b;
			alu_and: result = a & b;
			alu_or:  result = a | b;
			alu_slt: result = ($signed(a) < $signed(b)) ? xlen'(1) : '0; // Signed compare
			alu_sll: result = b << shamt;
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

`default_nettype wire

// File: control.sv
`default_nettype none

module control import mips_pkg::*; (
	input  op_t    opcode,
	input  funct_t funct,
	decode_ctrl_if.decoder ctrl
);

	always_comb begin
		// Start from a bubble, nothing is written
		ctrl.regwrite  = 1'b0;
		ctrl.regdst    = 1'b0;
		ctrl.memtoreg  = 1'b0;
		ctrl.memread   = 1'b0;
		ctrl.memwrite  = 1'b0;
		ctrl.isbranch  = 1'b0;
		ctrl.isjump    = 1'b0;
		ctrl.alusrc    = 1'b0;
		ctrl.zero_ext  = 1'b0;
		ctrl.alu_class = cls_add;

		case (opcode)
			op_rtype: begin
				case (funct)
					// sll shifts rt by shamt, so b stays the register operand
					fn_add, fn_sub, fn_and, fn_or, fn_slt, fn_sll: begin
						ctrl.regwrite  = 1'b1;
						ctrl.regdst    = 1'b1;
						ctrl.alu_class = cls_funct;
					end
					default: ; // Unsupported funct stays a bubble
				endcase
			end
			op_addi: begin
				ctrl.regwrite = 1'b1;
				ctrl.alusrc   = 1'b1;
			end
			op_ori: begin
				ctrl.regwrite  = 1'b1;
				ctrl.alusrc    = 1'b1;
				ctrl.zero_ext  = 1'b1;
				ctrl.alu_class = cls_or;
			end
			op_lw: begin
				ctrl.regwrite = 1'b1;
				ctrl.alusrc   = 1'b1;
				ctrl.memtoreg = 1'b1;
				ctrl.memread  = 1'b1;
			end
			op_sw: begin
				ctrl.alusrc   = 1'b1;
				ctrl.memwrite = 1'b1;
			end
			op_beq: begin
				ctrl.isbranch  = 1'b1;
				ctrl.alu_class = cls_sub; // Zero flag gives equality
			end
			op_j: ctrl.isjump = 1'b1;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: cpu.sv
`default_nettype none

module cpu import mips_pkg::*; #(
	parameter int dmem_depth_log2 = 8
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [xlen-1:0]       imem_instr,
	output logic [xlen-1:0]       imem_addr,
	output logic                  retire_valid,
	output logic [reg_addr_w-1:0] retire_reg,
	output logic [xlen-1:0]       retire_data
);

	// Fetch
	logic [xlen-1:0] pc;
	logic [xlen-1:0] if_pc_next;
	logic [xlen-1:0] pc_in;

	// Decode
	logic [xlen-1:0] id_instr;
	logic [xlen-1:0] id_pc_next;
	logic [xlen-1:0] id_imm;
	logic [xlen-1:0] id_pc_jump;
	logic [xlen-1:0] id_rs_data;
	logic [xlen-1:0] id_rt_data;

	// Execute
	logic                  ex_regwrite;
	logic                  ex_regdst;
	logic                  ex_memtoreg;
	logic                  ex_memread;
	logic                  ex_memwrite;
	logic                  ex_isbranch;
	logic                  ex_isjump;
	logic                  ex_alusrc;
	alu_class_t            ex_alu_class;
	logic [xlen-1:0]       ex_pc_next;
	logic [xlen-1:0]       ex_rs_data;
	logic [xlen-1:0]       ex_rt_data;
	logic [xlen-1:0]       ex_imm;
	logic [xlen-1:0]       ex_pc_jump;
	logic [reg_addr_w-1:0] ex_rt;
	logic [reg_addr_w-1:0] ex_rd;
	logic [xlen-1:0]       ex_alu_b;
	logic [xlen-1:0]       ex_alu_result;
	logic                  ex_zero;
	logic [reg_addr_w-1:0] ex_wreg;
	logic [xlen-1:0]       ex_pc_branch;

	// Memory
	logic                  mem_regwrite;
	logic                  mem_memtoreg;
	logic                  mem_memread;
	logic                  mem_memwrite;
	logic                  mem_isbranch;
	logic [xlen-1:0]       mem_pc_branch;
	logic                  mem_zero;
	logic [xlen-1:0]       mem_alu_result;
	logic [xlen-1:0]       mem_rt_data;
	logic [reg_addr_w-1:0] mem_wreg;
	logic [xlen-1:0]       mem_rdata;
	logic                  take_branch;

	// Writeback
	logic                  wb_regwrite;
	logic                  wb_memtoreg;
	logic [xlen-1:0]       wb_memout;
	logic [xlen-1:0]       wb_alu_result;
	logic [reg_addr_w-1:0] wb_wreg;
	logic [xlen-1:0]       wb_wdata;

	logic flush_front; // Clears IF/ID and ID/EX
	logic flush_ex_mem;

	decode_ctrl_if id_ctrl ();

	assign take_branch  = mem_isbranch & mem_zero;
	assign flush_front  = take_branch | ex_isjump;
	assign flush_ex_mem = take_branch;

	assign if_pc_next = pc + 32'd4;
	assign imem_addr  = pc;

	// Older branch wins over a younger jump
	assign pc_in = take_branch ? mem_pc_branch :
		ex_isjump ? ex_pc_jump : if_pc_next;

	always_ff @(posedge clk) begin
		if (!rst_n) pc <= '0;
		else pc <= pc_in;
	end

	always_ff @(posedge clk) begin
		if (!rst_n || flush_front) id_instr <= '0; // All-zero word is a nop
		else id_instr <= imem_instr;
	end

	always_ff @(posedge clk) begin
		id_pc_next <= if_pc_next;
	end

	control control (
		.opcode (op_t'(id_instr[31:26])),
		.funct  (funct_t'(id_instr[5:0])),
		.ctrl   (id_ctrl)
	);

	regfile regfile (
		.clk     (clk),
		.rst_n   (rst_n),
		.rs_addr (id_instr[25:21]),
		.rt_addr (id_instr[20:16]),
		.rs_data (id_rs_data),
		.rt_data (id_rt_data),
		.we      (wb_regwrite),
		.wr_addr (wb_wreg),
		.wr_data (wb_wdata)
	);

	assign id_imm = id_ctrl.zero_ext ? {{(xlen-16){1'b0}}, id_instr[15:0]} :
		{{(xlen-16){id_instr[15]}}, id_instr[15:0]};
	assign id_pc_jump = {id_pc_next[31:28], id_instr[25:0], 2'b00};

	always_ff @(posedge clk) begin
		if (!rst_n || flush_front) begin
			ex_regwrite  <= 1'b0;
			ex_regdst    <= 1'b0;
			ex_memtoreg  <= 1'b0;
			ex_memread   <= 1'b0;
			ex_memwrite  <= 1'b0;
			ex_isbranch  <= 1'b0;
			ex_isjump    <= 1'b0;
			ex_alusrc    <= 1'b0;
			ex_alu_class <= cls_add;
		end else begin
			ex_regwrite  <= id_ctrl.regwrite;
			ex_regdst    <= id_ctrl.regdst;
			ex_memtoreg  <= id_ctrl.memtoreg;
			ex_memread   <= id_ctrl.memread;
			ex_memwrite  <= id_ctrl.memwrite;
			ex_isbranch  <= id_ctrl.isbranch;
			ex_isjump    <= id_ctrl.isjump;
			ex_alusrc    <= id_ctrl.alusrc;
			ex_alu_class <= id_ctrl.alu_class;
		end
	end

	always_ff @(posedge clk) begin
		ex_pc_next <= id_pc_next;
		ex_rs_data <= id_rs_data;
		ex_rt_data <= id_rt_data;
		ex_imm     <= id_imm;
		ex_pc_jump <= id_pc_jump;
		ex_rt      <= id_instr[20:16];
		ex_rd      <= id_instr[15:11];
	end

	assign ex_alu_b     = ex_alusrc ? ex_imm : ex_rt_data;
	assign ex_wreg      = ex_regdst ? ex_rd : ex_rt;
	assign ex_pc_branch = ex_pc_next + (ex_imm << 2);

	// funct and shamt ride along in the low immediate bits
	alu alu (
		.alu_class (ex_alu_class),
		.funct     (funct_t'(ex_imm[5:0])),
		.a         (ex_rs_data),
		.b         (ex_alu_b),
		.shamt     (ex_imm[10:6]),
		.result    (ex_alu_result),
		.zero      (ex_zero)
	);

	always_ff @(posedge clk) begin
		if (!rst_n || flush_ex_mem) begin
			mem_regwrite <= 1'b0;
			mem_memtoreg <= 1'b0;
			mem_memread  <= 1'b0;
			mem_memwrite <= 1'b0;
			mem_isbranch <= 1'b0;
		end else begin
			mem_regwrite <= ex_regwrite;
			mem_memtoreg <= ex_memtoreg;
			mem_memread  <= ex_memread;
			mem_memwrite <= ex_memwrite;
			mem_isbranch <= ex_isbranch;
		end
	end

	always_ff @(posedge clk) begin
		mem_pc_branch  <= ex_pc_branch;
		mem_zero       <= ex_zero;
		mem_alu_result <= ex_alu_result;
		mem_rt_data    <= ex_rt_data;
		mem_wreg       <= ex_wreg;
	end

	data_mem #(
		.depth_log2 (dmem_depth_log2)
	) dmem (
		.clk   (clk),
		.rst_n (rst_n),
		.addr  (mem_alu_result),
		.wdata (mem_rt_data),
		.we    (mem_memwrite),
		.rdata (mem_rdata)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_regwrite <= 1'b0;
			wb_memtoreg <= 1'b0;
		end else begin
			wb_regwrite <= mem_regwrite;
			wb_memtoreg <= mem_memtoreg;
		end
	end

	always_ff @(posedge clk) begin
		wb_memout     <= mem_memread ? mem_rdata : '0; // Load data only on a read
		wb_alu_result <= mem_alu_result;
		wb_wreg       <= mem_wreg;
	end

	assign wb_wdata = wb_memtoreg ? wb_memout : wb_alu_result;

	assign retire_valid = wb_regwrite && (wb_wreg != '0);
	assign retire_reg   = wb_wreg;
	assign retire_data  = wb_wdata;

endmodule

`default_nettype wire

// File: cpu_patterns.txt
// Words from @000 are the program, one instruction per word; @100 holds program length, retire count
// Words from @102 are expected retires as triples: test group, register, data
@000
20010005 2002FFFD 34038001 00000000 00000000 // addi r1, addi r2 -3, ori r3
00222020 00222822 00233024 00233825 0041402A // add, sub, and, or, slt r8
0022482A 00015100 00025F00 20200007 200C0040 // slt r9, sll r10, sll r11, addi r0, addi r12
00000000 00000000 AD870000 AD850004 8D8D0000 // sw 0(r12), sw 4(r12), lw r13
8D8E0004 10210003 200F0011 200F0022 200F0033 // lw r14, beq taken, three skipped
20100044 10220005 20110055 0800001F 20120066 // beq target, beq not taken, j 31
20120077 20130088 00000000 00000000 0271A020 // jump target, add r20
@100
00000023 00000012
@102
00000002 00000001 00000005
00000002 00000002 FFFFFFFD
00000002 00000003 00008001
00000002 00000004 00000002
00000002 00000005 00000008
00000002 00000006 00000001
00000002 00000007 00008005
00000002 00000008 00000001
00000002 00000009 00000000
00000003 0000000A 00000050
00000003 0000000B D0000000
00000004 0000000C 00000040
00000004 0000000D 00008005
00000004 0000000E 00000008
00000005 00000010 00000044
00000005 00000011 00000055
00000006 00000013 00000088
00000006 00000014 000000DD

// File: data_mem.sv
`default_nettype none

module data_mem import mips_pkg::*; #(
	parameter int depth_log2 = 8
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic [xlen-1:0] addr,
	input  logic [xlen-1:0] wdata,
	input  logic            we,
	output logic [xlen-1:0] rdata
);

	localparam int depth = 1 << depth_log2;

	logic [xlen-1:0]       mem [depth];
	logic [depth_log2-1:0] word_addr;

	assign word_addr = addr[depth_log2+1:2]; // Byte offset ignored

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < depth; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[word_addr] <= wdata;
		end
	end

	assign rdata = mem[word_addr];

endmodule

`default_nettype wire

// File: decode_ctrl_if.sv
`default_nettype none

interface decode_ctrl_if import mips_pkg::*; ();

	logic       regwrite;
	logic       regdst;    // Destination is rd, else rt
	logic       memtoreg;
	logic       memread;
	logic       memwrite;
	logic       isbranch;
	logic       isjump;
	logic       alusrc;    // Second operand is the immediate
	logic       zero_ext;  // Zero-extend the immediate
	alu_class_t alu_class;

	modport decoder (
		output regwrite, regdst, memtoreg, memread, memwrite,
		output isbranch, isjump, alusrc, zero_ext, alu_class
	);

	modport pipeline (
		input regwrite, regdst, memtoreg, memread, memwrite,
		input isbranch, isjump, alusrc, zero_ext, alu_class
	);

endinterface

`default_nettype wire

// File: mips_pkg.sv
`default_nettype none

package mips_pkg;

	parameter int xlen       = 32; // Data and address width
	parameter int reg_addr_w = 5;  // Register index width

	// Primary opcode field, instr[31:26]
	typedef enum logic [5:0] {
		op_rtype = 6'h00,
		op_j     = 6'h02,
		op_beq   = 6'h04,
		op_addi  = 6'h08,
		op_ori   = 6'h0d,
		op_lw    = 6'h23,
		op_sw    = 6'h2b
	} op_t;

	// Function field of R-type words, instr[5:0]
	typedef enum logic [5:0] {
		fn_sll = 6'h00,
		fn_add = 6'h20,
		fn_sub = 6'h22,
		fn_and = 6'h24,
		fn_or  = 6'h25,
		fn_slt = 6'h2a
	} funct_t;

	// Operation class chosen by the main decoder
	typedef enum logic [1:0] {
		cls_add   = 2'd0, // addi, lw, sw
		cls_sub   = 2'd1, // beq
		cls_or    = 2'd2, // ori
		cls_funct = 2'd3  // R-type, ALU looks at funct
	} alu_class_t;

	// Resolved ALU operation
	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt,
		alu_sll
	} alu_op_t;

endpackage

`default_nettype wire

// File: regfile.sv
`default_nettype none

module regfile import mips_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [reg_addr_w-1:0] rs_addr,
	input  logic [reg_addr_w-1:0] rt_addr,
	output logic [xlen-1:0]       rs_data,
	output logic [xlen-1:0]       rt_data,
	input  logic                  we,
	input  logic [reg_addr_w-1:0] wr_addr,
	input  logic [xlen-1:0]       wr_data
);

	localparam int nregs = 1 << reg_addr_w;

	logic [xlen-1:0] regs [nregs];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < nregs; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Writeback data bypasses the array for a same-cycle read
	assign rs_data = (rs_addr == '0) ? '0 :
		(we && wr_addr == rs_addr) ? wr_data : regs[rs_addr];
	assign rt_data = (rt_addr == '0) ? '0 :
		(we && wr_addr == rt_addr) ? wr_data : regs[rt_addr];

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_cpu -f all.f -o vtb_cpu || exit 1
out=$(./obj_dir/vtb_cpu)
echo "$out"
echo "$out" | grep -q "TEST RESULT: PASS" && exit 0 || exit 1

// File: tb_cpu.sv
`default_nettype none

module tb_cpu;

	localparam int info_base    = 'h100; // Program length, then retire count
	localparam int exp_base     = 'h102; // Group, register, data triples
	localparam int wait_limit   = 200;
	localparam int quiet_cycles = 20;

	logic        clk;
	logic        rst_n;
	logic [31:0] imem_instr;
	logic [31:0] imem_addr;
	logic        retire_valid;
	logic [4:0]  retire_reg;
	logic [31:0] retire_data;

	logic [31:0] pat [0:511];
	int          prog_len;
	int          exp_count;
	int          pass_count;
	int          fail_count;

	cpu #(
		.dmem_depth_log2 (8)
	) i_cpu (
		.clk          (clk),
		.rst_n        (rst_n),
		.imem_instr   (imem_instr),
		.imem_addr    (imem_addr),
		.retire_valid (retire_valid),
		.retire_reg   (retire_reg),
		.retire_data  (retire_data)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] pattern_word(input int addr);
		return pat[addr[8:0]];
	endfunction

	function automatic string test_name(input int id);
		case (id)
			1: return "reset";
			2: return "arithmetic and logic";
			3: return "shift and register 0";
			4: return "store and load";
			5: return "branch";
			6: return "jump";
			default: return "no extra retire";
		endcase
	endfunction

	task automatic report_test(input int id, input int fails_before);
		$display("test %0d %s: %s", id, test_name(id),
			(fail_count == fails_before) ? "ok" : "failed");
	endtask

	// Wait on falling edges for the next retire event
	task automatic wait_retire(output bit seen);
		int n;
		seen = 1'b0;
		n = 0;
		while (!seen && n < wait_limit) begin
			@(negedge clk);
			n++;
			if (retire_valid === 1'b1) seen = 1'b1;
		end
	endtask

	// Instruction memory, nop past the end of the program
	always @(negedge clk) begin
		if ({2'b00, imem_addr[31:2]} < prog_len) begin
			imem_instr <= pattern_word(int'(imem_addr[31:2]));
		end else begin
			imem_instr <= 32'h0000_0000;
		end
	end

	initial begin : main
		bit          seen;
		bit          aborted;
		bit          extra;
		int          group;
		int          group_fails;
		logic [31:0] exp_reg;
		logic [31:0] exp_data;
		clk        = 1'b0;
		rst_n      = 1'b0;
		imem_instr = 32'h0000_0000;
		pass_count = 0;
		fail_count = 0;
		aborted    = 1'b0;
		$readmemh("cpu_patterns.txt", pat);
		prog_len  = int'(pattern_word(info_base));
		exp_count = int'(pattern_word(info_base + 1));

		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		group_fails = fail_count;
		if (imem_addr !== 32'h0000_0000) begin
			$display("ERR imem_addr expected %h actual %h", 32'h0, imem_addr);
			fail_count++;
		end else pass_count++;
		// First word needs four cycles before it can retire
		for (int c = 0; c < 4; c++) begin
			if (c > 0) @(negedge clk);
			if (retire_valid !== 1'b0) begin
				$display("ERR retire_valid expected %h actual %h", 1'b0, retire_valid);
				fail_count++;
			end else pass_count++;
		end
		report_test(1, group_fails);

		group = 0;
		for (int i = 0; i < exp_count && !aborted; i++) begin
			if (int'(pattern_word(exp_base + 3 * i)) != group) begin
				group       = int'(pattern_word(exp_base + 3 * i));
				group_fails = fail_count;
			end
			exp_reg  = pattern_word(exp_base + 3 * i + 1);
			exp_data = pattern_word(exp_base + 3 * i + 2);
			wait_retire(seen);
			if (!seen) begin
				$display("timeout while waiting for retire %0d to register %0d", i, exp_reg);
				fail_count++;
				aborted = 1'b1;
			end else begin
				if (retire_reg !== exp_reg[4:0]) begin
					$display("ERR retire_reg expected %h actual %h", exp_reg[4:0], retire_reg);
					fail_count++;
				end else pass_count++;
				if (retire_data !== exp_data) begin
					$display("ERR retire_data expected %h actual %h", exp_data, retire_data);
					fail_count++;
				end else pass_count++;
			end
			if (aborted || i == exp_count - 1 ||
				int'(pattern_word(exp_base + 3 * i + 3)) != group) begin
				report_test(group, group_fails);
			end
		end

		if (!aborted) begin
			group_fails = fail_count;
			extra       = 1'b0;
			repeat (quiet_cycles) begin
				@(negedge clk);
				if (retire_valid !== 1'b0 && !extra) begin
					$display("unexpected retire to register %0d after the last expected one",
						retire_reg);
					extra = 1'b1;
				end
			end
			if (extra) fail_count++;
			else pass_count++;
			report_test(7, group_fails);
		end

		$display("checks passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
